/* tests/uart_trace.txt */
rx 55 0
rx a3 0
rxbad 3c 0
rx 0f 0
glitch 00 0
rx c6 0
rxover 81 0
rx 5a 1
rx 7e 0
tx a5 0
tx 01 0
tx fe 0

/* tb.f */
src/uart_cfg_pkg.sv
src/uart_frame_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_top.sv
tests/tb_uart.sv

/* run.sh */
#!/bin/sh
# build the UART testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_uart -f tb.f -o sim_uart
output=$(./obj_dir/sim_uart)
echo "$output"
if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* tests/tb_uart.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_uart
    import uart_frame_pkg::*;
();

    localparam int bit_clocks = 8;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 rxd;
    logic                 rx_ack;
    logic                 tx_req;
    logic [data_bits-1:0] tx_data;
    wire                  txd;
    wire  [data_bits-1:0] rx_data;
    wire                  rx_frame_err;
    wire                  rx_overrun;
    wire                  rx_req;
    wire                  tx_ack;

    string                op_q[$];
    logic [7:0]           byte_q[$];
    logic                 flag_q[$];  // expected rx_overrun of the delivered byte
    int                   n_ops = 0;
    int                   errors = 0;
    int                   checks = 0;

    uart_top #(
        .CYCLES_PER_BIT(bit_clocks)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rxd          (rxd),
        .txd          (txd),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun),
        .rx_req       (rx_req),
        .rx_ack       (rx_ack),
        .tx_data      (tx_data),
        .tx_req       (tx_req),
        .tx_ack       (tx_ack)
    );

    always #2 clk = ~clk;

    // every drive and every sample happens 1 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // on_tx picks tx_ack, otherwise rx_req is watched
    task automatic wait_level(input string name, input bit on_tx, input logic level,
                              input int limit, output int waited);
        waited = 0;
        while (((on_tx ? tx_ack : rx_req) !== level) && waited < limit) begin
            tick(1);
            waited++;
        end
        if ((on_tx ? tx_ack : rx_req) !== level) begin
            errors++;
            $display("%s: handshake line did not reach %0d within %0d clocks",
                     name, level, limit);
        end
    endtask

    task automatic send_frame(input logic [7:0] value, input logic stop);
        rxd = 1'b0;
        tick(bit_clocks);
        for (int i = 0; i < data_bits; i++) begin
            rxd = value[i]; // LSB first
            tick(bit_clocks);
        end
        rxd = stop;
        tick(bit_clocks);
        rxd = 1'b1;
    endtask

    task automatic receive(input string name, input logic [7:0] value,
                           input logic frame_err, input logic overrun);
        int waited;
        int delay;
        wait_level(name, 1'b0, 1'b1, 4 * bit_clocks, waited);
        check_value({name, " rx_data"}, int'(value), int'(rx_data));
        check_value({name, " rx_frame_err"}, int'(frame_err), int'(rx_frame_err));
        check_value({name, " rx_overrun"}, int'(overrun), int'(rx_overrun));
        delay = $urandom % 4;
        repeat (delay) begin
            tick(1);
            if (!rx_req) begin
                errors++;
                $display("%s: rx_req fell before rx_ack was given", name);
            end
        end
        rx_ack = 1'b1;
        wait_level(name, 1'b0, 1'b0, 4, waited);
        rx_ack = 1'b0;
        tick(1);
    endtask

    task automatic send_tx(input string name, input logic [7:0] value);
        int         waited;
        logic [9:0] frame;
        tx_data = value;
        tx_req  = 1'b1;
        wait_level(name, 1'b1, 1'b1, 4 * 10 * bit_clocks, waited);
        tx_req = 1'b0; // the start bit began on the edge that raised tx_ack
        wait_level(name, 1'b1, 1'b0, bit_clocks / 2, waited);
        tick(bit_clocks / 2 - waited);
        frame[0] = txd;
        for (int j = 1; j < 10; j++) begin
            tick(bit_clocks);
            frame[j] = txd;
        end
        check_value({name, " txd frame"}, int'({1'b1, value, 1'b0}), int'(frame));
    endtask

    initial begin
        wait (n_ops > 0);
        #(n_ops * 2 * 10 * bit_clocks * 4 * 2);
        $display("watchdog expired before the trace was finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int         fd;
        int         flag;
        int         seen;
        string      op;
        logic [7:0] value;
        void'($urandom(68608));
        rst_n   = 1'b0;
        rxd     = 1'b1;
        rx_ack  = 1'b0;
        tx_req  = 1'b0;
        tx_data = '0;
        fd = $fopen("tests/uart_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/uart_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fscanf(fd, "%s %h %d\n", op, value, flag) == 3) begin
                    op_q.push_back(op);
                    byte_q.push_back(value);
                    flag_q.push_back(flag != 0);
                end else begin
                    break;
                end
            end
            $fclose(fd);
        end
        n_ops = op_q.size();
        tick(5);
        rst_n = 1'b1;
        tick(1);
        check_value("reset txd", 1, int'(txd));
        check_value("reset rx_req", 0, int'(rx_req));
        check_value("reset tx_ack", 0, int'(tx_ack));
        for (int i = 0; i < n_ops; i++) begin
            if (op_q[i] == "rx" || op_q[i] == "rxbad") begin
                send_frame(byte_q[i], op_q[i] == "rx");
                receive(op_q[i], byte_q[i], op_q[i] == "rxbad", flag_q[i]);
                tick(2 * bit_clocks);
            end else if (op_q[i] == "glitch") begin
                rxd = 1'b0;
                tick(2);
                rxd  = 1'b1;
                seen = 0;
                for (int k = 0; k < 2 * 10 * bit_clocks; k++) begin
                    tick(1);
                    if (rx_req) begin
                        seen++;
                    end
                end
                check_value("glitch rx_req clocks", 0, seen);
            end else if (op_q[i] == "rxover") begin
                // rx_ack stays low over both frames, so the second one finds the register busy
                send_frame(byte_q[i], 1'b1);
                send_frame(~byte_q[i], 1'b1);
                tick(bit_clocks);
                receive("rxover", byte_q[i], 1'b0, flag_q[i]);
                tick(2 * bit_clocks);
            end else if (op_q[i] == "tx") begin
                send_tx("tx", byte_q[i]);
            end else begin
                errors++;
                $display("unknown operation %s in the trace", op_q[i]);
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/100ps
`default_nettype none

// receiver and transmitter side by side, each with its own handshake
module uart_top
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
#(
    parameter int CYCLES_PER_BIT = default_cycles_per_bit
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rxd,
    output wire logic                 txd,
    output wire logic [data_bits-1:0] rx_data,
    output wire logic                 rx_frame_err,
    output wire logic                 rx_overrun,
    output wire logic                 rx_req,
    input  wire logic                 rx_ack,
    input  wire logic [data_bits-1:0] tx_data,
    input  wire logic                 tx_req,
    output wire logic                 tx_ack
);

    uart_rx #(
        .CYCLES_PER_BIT(CYCLES_PER_BIT)
    ) u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .data      (rx_data),
        .frame_err (rx_frame_err),
        .overrun   (rx_overrun),
        .req       (rx_req),
        .ack       (rx_ack)
    );

    uart_tx #(
        .CYCLES_PER_BIT(CYCLES_PER_BIT)
    ) u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (tx_data),
        .req   (tx_req),
        .ack   (tx_ack),
        .txd   (txd)
    );

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
#(
    parameter int CYCLES_PER_BIT = default_cycles_per_bit
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [data_bits-1:0] data,
    input  wire logic                 req,
    output logic                      ack,
    output logic                      txd
);

    localparam logic [cycle_count_width-1:0] bit_last =
        cycle_count_width'(CYCLES_PER_BIT - 1);
    localparam logic [2:0] last_index = 3'(data_bits - 1);

    tx_state_t                    state;
    logic [cycle_count_width-1:0] cycle_cnt;
    logic [2:0]                   bit_idx;
    logic [data_bits-1:0]         shift_reg; // bit 0 is always the next bit to go out
    logic                         accept;
    logic                         bit_done;

    // a new byte is taken only once the line is idle and the last handshake has returned to zero
    assign accept   = (state == tx_idle) && req && !ack;
    assign bit_done = (cycle_cnt == bit_last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (accept) begin
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= tx_idle;
            txd       <= 1'b1;
            cycle_cnt <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    cycle_cnt <= '0;
                    bit_idx   <= '0;
                    if (accept) begin
                        state <= tx_start;
                        txd   <= 1'b0; // start bit goes out with the ack
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        cycle_cnt <= '0;
                        state     <= tx_data;
                        txd       <= shift_reg[0];
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        cycle_cnt <= '0;
                        if (bit_idx == last_index) begin
                            state <= tx_stop;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift_reg[0];
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                tx_stop: begin
                    if (bit_done) begin
                        cycle_cnt <= '0;
                        state     <= tx_idle;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= tx_idle;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

    // byte latched on acceptance, then shifted one place at the end of each bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= data;
        end else if ((state == tx_start || state == tx_data) && bit_done) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        state == tx_idle |-> txd);

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
#(
    parameter int CYCLES_PER_BIT = default_cycles_per_bit
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rxd,
    output logic      [data_bits-1:0] data,
    output logic                      frame_err,
    output logic                      overrun,
    output logic                      req,
    input  wire logic                 ack
);

    // last count of a full bit period and of the half period up to the start check
    localparam logic [cycle_count_width-1:0] bit_last =
        cycle_count_width'(CYCLES_PER_BIT - 1);
    localparam logic [cycle_count_width-1:0] mid_last =
        cycle_count_width'((CYCLES_PER_BIT - 1) / 2 - 1);
    localparam logic [2:0] last_index = 3'(data_bits - 1);

    logic                         rx_meta;
    logic                         rx_sync;    // rxd two clocks late
    logic                         rx_prev;    // rx_sync one clock later, for edge detection
    rx_state_t                    state;
    logic [cycle_count_width-1:0] cycle_cnt;
    logic [2:0]                   bit_idx;
    logic [data_bits-1:0]         shift_data;
    logic                         stop_bit;
    logic                         overrun_mark; // a byte was lost since the last delivery
    logic                         bit_tick;
    logic                         busy;

    assign bit_tick = (cycle_cnt == bit_last);

    // the output register is taken until ack has been seen low again
    assign busy = req || ack;

    // the line idles high, so the synchronizer resets to 1 to avoid a false start edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= rx_idle;
            cycle_cnt <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                rx_idle: begin
                    cycle_cnt <= '0;
                    bit_idx   <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (cycle_cnt == mid_last) begin
                        cycle_cnt <= '0;
                        state     <= rx_sync ? rx_idle : rx_data; // high again means a glitch
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        if (bit_idx == last_index) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        state     <= rx_hold;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                rx_hold: begin
                    state <= rx_idle;
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // sampled bits of the frame in flight
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_tick) begin
            shift_data[bit_idx] <= rx_sync;
        end
        if (state == rx_stop && bit_tick) begin
            stop_bit <= rx_sync;
        end
        if (state == rx_hold && !busy) begin
            data <= shift_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req          <= 1'b0;
            frame_err    <= 1'b0;
            overrun      <= 1'b0;
            overrun_mark <= 1'b0;
        end else begin
            if (req && ack) begin
                req <= 1'b0;
            end
            if (state == rx_hold) begin
                if (busy) begin
                    overrun_mark <= 1'b1; // previous byte still in its handshake, drop this one
                end else begin
                    req          <= 1'b1;
                    frame_err    <= !stop_bit;
                    overrun      <= overrun_mark;
                    overrun_mark <= 1'b0;
                end
            end
        end
    end

    // the consumer must have acknowledged before req goes away
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) && $past(rst_n) |-> $past(ack));

    assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> $stable(data));

endmodule

`default_nettype wire

/* src/uart_frame_pkg.sv */
`default_nettype none

// frame layout and the state encodings of both serial engines
package uart_frame_pkg;

    // 8N1 framing, one start bit, data_bits data bits LSB first, one stop bit
    localparam int data_bits = 8;

    // receiver states
    // rx_hold is the single clock after the stop sample where the byte is handed over
    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop,
        rx_hold
    } rx_state_t;

    // transmitter line states, the handshake is tracked outside this machine
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

`default_nettype wire

/* src/uart_cfg_pkg.sv */
`default_nettype none

// line timing and configuration shared by the receiver, transmitter and top level
package uart_cfg_pkg;

    // clocks per bit period at 1 MHz and 9600 baud
    localparam int default_cycles_per_bit = 104;

    // width of the bit-period counters in both directions
    // 16 bits covers any divider up to 65535 clocks per bit
    localparam int cycle_count_width = 16;

endpackage

`default_nettype wire
